//--- design/hbridge_pkg.sv
/*
  shared types and constants for the resonant-tank H-bridge core
  gate bit order {M4, M3, M2, M1}, leg 1 = M1/M3, leg 2 = M2/M4
  CTRL register: bit 0 enable, bits 2:1 mode
  STATUS register: bit 0 fault, bits 2:1 phase, write bit 0 = fault clear
*/
package hbridge_pkg;

   // ==============================
   // widths and value types
   // ==============================
   localparam int GATE_N = 4;                 // four MOSFETs

   typedef logic signed [13:0] adc_t;         // tank sample
   typedef logic signed [29:0] surf_t;        // vc*cos - ic*sin
   typedef logic signed [15:0] coef_t;        // Q1.14
   typedef logic        [3:0]  angle_t;       // k * pi/16
   typedef logic        [15:0] band_t;        // zero band half width
   typedef logic        [7:0]  dt_t;          // dead time, clock cycles
   typedef logic [GATE_N-1:0]  gate_t;
   typedef logic        [4:0]  axi_addr_t;
   typedef logic        [31:0] axi_data_t;
   typedef logic        [4:0]  seq_cnt_t;     // start-up phase counter

   typedef enum logic [1:0] {
      SIG_ZERO = 2'b00,
      SIG_POS  = 2'b01,
      SIG_NEG  = 2'b11                        // two's complement -1
   } sigma_e;

   typedef enum logic [1:0] {
      MODE_OFF   = 2'd0,
      MODE_THETA = 2'd1,                      // two-level, theta only
      MODE_MIXED = 2'd2,                      // three-level with zero band
      MODE_RSVD  = 2'd3
   } mode_e;

   typedef enum logic [1:0] {
      PH_IDLE   = 2'd0,
      PH_BOOT   = 2'd1,
      PH_PRECHG = 2'd2,
      PH_RUN    = 2'd3
   } phase_e;

   typedef struct packed {
      logic   enable;
      mode_e  mode;
      angle_t theta;
      band_t  band;
      dt_t    deadtime;
      logic   fault_clr_pulse;                // one cycle wide
   } ctrl_cfg_s;

   // ==============================
   // start-up and gate patterns
   // ==============================
   localparam seq_cnt_t BOOT_CYCLES   = 5'd12;
   localparam seq_cnt_t PRECHG_CYCLES = 5'd18;

   localparam gate_t GATE_POS  = 4'b1001;     // M1 + M4
   localparam gate_t GATE_NEG  = 4'b0110;     // M2 + M3
   localparam gate_t GATE_ZERO = 4'b1100;     // both low sides
   localparam gate_t GATE_BOOT = 4'b1100;     // bootstrap charge
   localparam gate_t GATE_OFF  = 4'b0000;

   // ==============================
   // register map
   // ==============================
   localparam axi_addr_t REG_CTRL   = 5'h00;
   localparam axi_addr_t REG_THETA  = 5'h04;
   localparam axi_addr_t REG_BAND   = 5'h08;
   localparam axi_addr_t REG_DEAD   = 5'h0C;
   localparam axi_addr_t REG_STATUS = 5'h10;

   localparam logic [1:0] AXI_OKAY = 2'b00;

   localparam angle_t THETA_RST = 4'd8;       // pi/2
   localparam band_t  BAND_RST  = 16'd0;
   localparam dt_t    DEAD_RST  = 8'd5;

endpackage

//--- design/axil_ctrl_regs.sv
/*
  AXI4-Lite slave, one outstanding write and one outstanding read
  AW and W are taken together, never apart
  unmapped addresses answer OKAY, read as 0, ignore writes
*/
`timescale 1ns/1ps

module axil_ctrl_regs (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  hbridge_pkg::axi_addr_t i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  hbridge_pkg::axi_data_t i_wdata,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output logic [1:0]             o_bresp,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   input  hbridge_pkg::axi_addr_t i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   output hbridge_pkg::axi_data_t o_rdata,
   output logic [1:0]             o_rresp,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   input  hbridge_pkg::phase_e    i_phase,
   input  logic                   i_fault,
   output hbridge_pkg::ctrl_cfg_s o_cfg
);
   import hbridge_pkg::*;

   ctrl_cfg_s cfg_q;
   axi_data_t rd_mux;
   logic      wr_fire;
   logic      rd_fire;

   assign wr_fire = o_awready & i_awvalid & o_wready & i_wvalid;
   assign rd_fire = o_arready & i_arvalid;
   assign o_bresp = AXI_OKAY;                 // no error responses
   assign o_rresp = AXI_OKAY;
   assign o_cfg   = cfg_q;

   // ==============================
   // write path
   // ==============================
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_awready <= 1'b0;
         o_wready  <= 1'b0;
         o_bvalid  <= 1'b0;
      end else begin
         // readies pulse once both channels wait and no response is pending
         o_awready <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
         o_wready  <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
         if (wr_fire)
            o_bvalid <= 1'b1;
         else if (i_bready)
            o_bvalid <= 1'b0;                 // held until taken
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cfg_q.enable          <= 1'b0;
         cfg_q.mode            <= MODE_OFF;
         cfg_q.theta           <= THETA_RST;
         cfg_q.band            <= BAND_RST;
         cfg_q.deadtime        <= DEAD_RST;
         cfg_q.fault_clr_pulse <= 1'b0;
      end else begin
         cfg_q.fault_clr_pulse <= 1'b0;       // default, pulse only
         if (wr_fire) begin
            case (i_awaddr)
               REG_CTRL: begin
                  cfg_q.enable <= i_wdata[0];
                  cfg_q.mode   <= mode_e'(i_wdata[2:1]);
               end
               REG_THETA:  cfg_q.theta           <= i_wdata[3:0];
               REG_BAND:   cfg_q.band            <= i_wdata[15:0];
               REG_DEAD:   cfg_q.deadtime        <= i_wdata[7:0];
               REG_STATUS: cfg_q.fault_clr_pulse <= i_wdata[0];
               default: ;                     // unmapped, dropped
            endcase
         end
      end
   end

   // ==============================
   // read path
   // ==============================
   always_comb begin
      case (i_araddr)
         REG_CTRL:   rd_mux = {29'd0, cfg_q.mode, cfg_q.enable};
         REG_THETA:  rd_mux = {28'd0, cfg_q.theta};
         REG_BAND:   rd_mux = {16'd0, cfg_q.band};
         REG_DEAD:   rd_mux = {24'd0, cfg_q.deadtime};
         REG_STATUS: rd_mux = {29'd0, i_phase, i_fault};
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_arready <= 1'b0;
         o_rvalid  <= 1'b0;
      end else begin
         o_arready <= i_arvalid & ~o_arready & ~o_rvalid;
         if (rd_fire)
            o_rvalid <= 1'b1;
         else if (i_rready)
            o_rvalid <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (rd_fire)
         o_rdata <= rd_mux;                   // stable while rvalid waits
   end

endmodule

//--- design/adc_capture.sv
/*
  tank sample capture, both channels on the one ADC clock
  samples are negated, the board senses with inverted polarity
  full-scale negative input wraps to itself
*/
`timescale 1ns/1ps

module adc_capture (
   input  logic              i_clk,
   input  logic              i_rst,
   input  hbridge_pkg::adc_t i_ada_data,
   input  hbridge_pkg::adc_t i_adb_data,
   input  logic              i_ada_or,
   input  logic              i_adb_or,
   output hbridge_pkg::adc_t o_vc,
   output hbridge_pkg::adc_t o_ic,
   output logic              o_over_range
);

   always_ff @(posedge i_clk) begin
      o_vc <= -i_ada_data;                    // capacitor voltage
      o_ic <= -i_adb_data;                    // inductor current
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_over_range <= 1'b0;
      else
         o_over_range <= i_ada_or | i_adb_or; // either channel clipped
   end

endmodule

//--- design/surface_law.sv
/*
  switching surface law, two register stages
  stage 1 forms vc*cos(theta) - ic*sin(theta), table in Q1.14
  stage 2 picks sigma and its gate pattern from the mode
  mode and band are taken as quasi-static
*/
`timescale 1ns/1ps

module surface_law (
   input  logic                i_clk,
   input  logic                i_rst,
   input  hbridge_pkg::adc_t   i_vc,
   input  hbridge_pkg::adc_t   i_ic,
   input  hbridge_pkg::angle_t i_theta,
   input  hbridge_pkg::band_t  i_band,
   input  hbridge_pkg::mode_e  i_mode,
   output hbridge_pkg::gate_t  o_gate,
   output hbridge_pkg::sigma_e o_sigma
);
   import hbridge_pkg::*;

   logic [31:0]        cs_pair;               // {cos, sin}
   coef_t              cos_c;
   coef_t              sin_c;
   surf_t              surf_q;
   logic signed [15:0] surf_hi;               // surface >>> 14
   logic        [15:0] surf_mag;
   sigma_e             sig_d;

   // cos/sin of k*pi/16, scaled by 2^14
   always_comb begin
      case (i_theta)
         4'd0:    cs_pair = {16'sd16384, 16'sd0};
         4'd1:    cs_pair = {16'sd16069, 16'sd3196};
         4'd2:    cs_pair = {16'sd15137, 16'sd6270};
         4'd3:    cs_pair = {16'sd13623, 16'sd9102};
         4'd4:    cs_pair = {16'sd11585, 16'sd11585};
         4'd5:    cs_pair = {16'sd9102, 16'sd13623};
         4'd6:    cs_pair = {16'sd6270, 16'sd15137};
         4'd7:    cs_pair = {16'sd3196, 16'sd16069};
         4'd8:    cs_pair = {16'sd0, 16'sd16384};
         4'd9:    cs_pair = {-16'sd3196, 16'sd16069};
         4'd10:   cs_pair = {-16'sd6270, 16'sd15137};
         4'd11:   cs_pair = {-16'sd9102, 16'sd13623};
         4'd12:   cs_pair = {-16'sd11585, 16'sd11585};
         4'd13:   cs_pair = {-16'sd13623, 16'sd9102};
         4'd14:   cs_pair = {-16'sd15137, 16'sd6270};
         default: cs_pair = {-16'sd16069, 16'sd3196};
      endcase
   end

   assign cos_c = cs_pair[31:16];
   assign sin_c = cs_pair[15:0];

   // ==============================
   // stage 1 products
   // ==============================
   always_ff @(posedge i_clk) begin
      surf_q <= i_vc * cos_c - i_ic * sin_c;  // |result| < 2^28
   end

   // ==============================
   // stage 2 decision
   // ==============================
   assign surf_hi  = surf_q[29:14];
   assign surf_mag = surf_hi[15] ? -surf_hi : surf_hi;

   always_comb begin
      sig_d = (surf_q > 0) ? SIG_POS : SIG_NEG;
      if (i_mode == MODE_MIXED && surf_mag <= i_band)
         sig_d = SIG_ZERO;                    // inside the band
      if (i_mode == MODE_OFF || i_mode == MODE_RSVD)
         sig_d = SIG_ZERO;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_sigma <= SIG_ZERO;
         o_gate  <= GATE_OFF;
      end else begin
         o_sigma <= sig_d;
         if (i_mode == MODE_OFF || i_mode == MODE_RSVD)
            o_gate <= GATE_OFF;               // all devices off
         else begin
            case (sig_d)
               SIG_POS: o_gate <= GATE_POS;
               SIG_NEG: o_gate <= GATE_NEG;
               default: o_gate <= GATE_ZERO;
            endcase
         end
      end
   end

endmodule

//--- design/startup_seq.sv
/*
  start-up phases: bootstrap charge, tank pre-charge, run
  registered output, one cycle behind the request
  dropping enable returns to idle with all gates off
*/
`timescale 1ns/1ps

module startup_seq (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_enable,
   input  hbridge_pkg::gate_t  i_law_gate,
   output hbridge_pkg::gate_t  o_req_gate,
   output hbridge_pkg::phase_e o_phase
);
   import hbridge_pkg::*;

   seq_cnt_t cnt;                             // cycles spent in phase

   always_ff @(posedge i_clk) begin
      if (i_rst || !i_enable) begin
         o_phase    <= PH_IDLE;
         o_req_gate <= GATE_OFF;
         cnt        <= '0;
      end else begin
         case (o_phase)
            PH_IDLE: begin
               o_phase    <= PH_BOOT;
               o_req_gate <= GATE_BOOT;       // low sides on
               cnt        <= 5'd1;
            end
            PH_BOOT: begin
               if (cnt == BOOT_CYCLES) begin
                  o_phase    <= PH_PRECHG;
                  o_req_gate <= GATE_POS;     // sigma forced to +1
                  cnt        <= 5'd1;
               end else begin
                  o_req_gate <= GATE_BOOT;
                  cnt        <= cnt + 5'd1;
               end
            end
            PH_PRECHG: begin
               if (cnt == PRECHG_CYCLES) begin
                  o_phase    <= PH_RUN;
                  o_req_gate <= i_law_gate;   // hand over to the law
               end else begin
                  o_req_gate <= GATE_POS;
                  cnt        <= cnt + 5'd1;
               end
            end
            default: o_req_gate <= i_law_gate;
         endcase
      end
   end

endmodule

//--- design/dead_time_gen.sv
/*
  rising-edge delay per gate
  a rising request shows after deadtime+1 cycles held high
  a falling request shows after one cycle
  a request dropped early restarts its count
*/
`timescale 1ns/1ps

module dead_time_gen (
   input  logic               i_clk,
   input  logic               i_rst,
   input  hbridge_pkg::gate_t i_req_gate,
   input  hbridge_pkg::dt_t   i_deadtime,
   output hbridge_pkg::gate_t o_gate
);
   import hbridge_pkg::*;

   dt_t cnt [GATE_N];                         // one counter per device

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_gate <= GATE_OFF;
         for (int g = 0; g < GATE_N; g++)
            cnt[g] <= '0;
      end else begin
         for (int g = 0; g < GATE_N; g++) begin
            if (!i_req_gate[g]) begin
               o_gate[g] <= 1'b0;             // turn-off passes at once
               cnt[g]    <= '0;
            end else if (!o_gate[g]) begin
               if (cnt[g] == i_deadtime)
                  o_gate[g] <= 1'b1;          // delay elapsed
               else
                  cnt[g] <= cnt[g] + 8'd1;
            end
         end
      end
   end

endmodule

//--- design/bridge_guard.sv
/*
  sticky fault latch and final gate mask
  over-range wins over a clear arriving in the same cycle
  gates drop on the same edge the fault sets
*/
`timescale 1ns/1ps

module bridge_guard (
   input  logic               i_clk,
   input  logic               i_rst,
   input  hbridge_pkg::gate_t i_gate,
   input  logic               i_over_range,
   input  logic               i_fault_clr,
   output hbridge_pkg::gate_t o_gate,
   output logic               o_fault
);
   import hbridge_pkg::*;

   logic fault_d;

   always_comb begin
      fault_d = o_fault;
      if (i_over_range)
         fault_d = 1'b1;
      else if (i_fault_clr)
         fault_d = 1'b0;                      // software clear
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_fault <= 1'b0;
         o_gate  <= GATE_OFF;
      end else begin
         o_fault <= fault_d;
         o_gate  <= fault_d ? GATE_OFF : i_gate;
      end
   end

endmodule

//--- design/hybrid_bridge_top.sv
/*
  H-bridge control core, everything on ADA_DCO
  both ADCs must be synchronous to ADA_DCO
  sample to gate is a fixed pipeline plus the dead time
*/
`timescale 1ns/1ps

module hybrid_bridge_top (
   input  logic                   ADA_DCO,
   input  logic                   i_rst,
   input  hbridge_pkg::adc_t      i_ada_data,
   input  hbridge_pkg::adc_t      i_adb_data,
   input  logic                   i_ada_or,
   input  logic                   i_adb_or,
   input  hbridge_pkg::axi_addr_t i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  hbridge_pkg::axi_data_t i_wdata,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output logic [1:0]             o_bresp,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   input  hbridge_pkg::axi_addr_t i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   output hbridge_pkg::axi_data_t o_rdata,
   output logic [1:0]             o_rresp,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   output hbridge_pkg::gate_t     o_gate,
   output logic                   o_fault
);
   import hbridge_pkg::*;

   ctrl_cfg_s cfg;
   adc_t      vc;
   adc_t      ic;
   logic      over_range;
   gate_t     law_gate;
   gate_t     req_gate;
   gate_t     dt_gate;
   phase_e    phase;

   // ==============================
   // pipeline
   // ==============================
   adc_capture u_adc (
      .i_clk(ADA_DCO), .i_rst(i_rst),
      .i_ada_data(i_ada_data), .i_adb_data(i_adb_data),
      .i_ada_or(i_ada_or), .i_adb_or(i_adb_or),
      .o_vc(vc), .o_ic(ic), .o_over_range(over_range)
   );

   surface_law u_law (
      .i_clk(ADA_DCO), .i_rst(i_rst),
      .i_vc(vc), .i_ic(ic),
      .i_theta(cfg.theta), .i_band(cfg.band), .i_mode(cfg.mode),
      .o_gate(law_gate),
      .o_sigma()                              // probe only, not used downstream
   );

   startup_seq u_seq (
      .i_clk(ADA_DCO), .i_rst(i_rst),
      .i_enable(cfg.enable), .i_law_gate(law_gate),
      .o_req_gate(req_gate), .o_phase(phase)
   );

   dead_time_gen u_dt (
      .i_clk(ADA_DCO), .i_rst(i_rst),
      .i_req_gate(req_gate), .i_deadtime(cfg.deadtime),
      .o_gate(dt_gate)
   );

   bridge_guard u_guard (
      .i_clk(ADA_DCO), .i_rst(i_rst),
      .i_gate(dt_gate), .i_over_range(over_range),
      .i_fault_clr(cfg.fault_clr_pulse),
      .o_gate(o_gate), .o_fault(o_fault)
   );

   // ==============================
   // register file
   // ==============================
   axil_ctrl_regs u_regs (
      .i_clk(ADA_DCO), .i_rst(i_rst),
      .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
      .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
      .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
      .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
      .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid),
      .i_rready(i_rready),
      .i_phase(phase), .i_fault(o_fault),
      .o_cfg(cfg)
   );

endmodule

//--- verification/hybrid_bridge_checker.sv
/*
  gate safety and bus hold checks, bound into the top level
  reports only through failing assertions
*/
`timescale 1ns/1ps

module hybrid_bridge_checker (
   input logic                   i_clk,
   input logic                   i_rst,
   input hbridge_pkg::gate_t     i_gate,
   input logic                   i_fault,
   input logic                   i_ada_or,
   input logic                   i_adb_or,
   input logic                   i_bvalid,
   input logic                   i_bready,
   input logic                   i_rvalid,
   input logic                   i_rready,
   input hbridge_pkg::axi_data_t i_rdata
);
   import hbridge_pkg::*;

   // no shoot-through on either leg
   a_leg1: assert property (@(posedge i_clk) disable iff (i_rst) !(i_gate[0] && i_gate[2]))
      else $error("leg 1 high and low side on together");
   a_leg2: assert property (@(posedge i_clk) disable iff (i_rst) !(i_gate[1] && i_gate[3]))
      else $error("leg 2 high and low side on together");

   // responses held until taken
   a_bhold: assert property (@(posedge i_clk) disable iff (i_rst)
                             i_bvalid && !i_bready |=> i_bvalid)
      else $error("write response dropped before bready");
   a_rhold: assert property (@(posedge i_clk) disable iff (i_rst)
                             i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
      else $error("read response dropped or changed before rready");

   // over-range pin to latched fault, capture then guard
   a_fault: assert property (@(posedge i_clk) disable iff (i_rst)
                             (i_ada_or || i_adb_or) |-> ##2 (i_fault && i_gate == GATE_OFF))
      else $error("over-range did not latch the fault and force the gates off");

endmodule

bind hybrid_bridge_top hybrid_bridge_checker u_checker (
   .i_clk(ADA_DCO), .i_rst(i_rst),
   .i_gate(o_gate), .i_fault(o_fault),
   .i_ada_or(i_ada_or), .i_adb_or(i_adb_or),
   .i_bvalid(o_bvalid), .i_bready(i_bready),
   .i_rvalid(o_rvalid), .i_rready(i_rready), .i_rdata(o_rdata)
);

//--- verification/tb_hybrid_bridge.sv
/*
  testbench for the H-bridge control core, run from the project root
  commands and expected values come from verification/bridge_patterns.txt
  one pattern line = four hex words, cmd arg data expect
  gate checks sample on the falling edge, a fixed 40 cycles after a change
*/
`timescale 1ns/1ps

module tb_hybrid_bridge;
   import hbridge_pkg::*;

   logic        ADA_DCO;
   logic        i_rst;
   adc_t        i_ada_data;
   adc_t        i_adb_data;
   logic        i_ada_or;
   logic        i_adb_or;
   axi_addr_t   i_awaddr;
   logic        i_awvalid;
   logic        o_awready;
   axi_data_t   i_wdata;
   logic        i_wvalid;
   logic        o_wready;
   logic [1:0]  o_bresp;
   logic        o_bvalid;
   logic        i_bready;
   axi_addr_t   i_araddr;
   logic        i_arvalid;
   logic        o_arready;
   axi_data_t   o_rdata;
   logic [1:0]  o_rresp;
   logic        o_rvalid;
   logic        i_rready;
   gate_t       o_gate;
   logic        o_fault;

   logic [31:0] pat [0:255];                  // 4 words per command
   int          n_cmds;
   int          err_gate  = 0;
   int          err_reg   = 0;
   int          err_phase = 0;
   int          err_fault = 0;
   int          err_other = 0;

   hybrid_bridge_top u_dut (.*);

   initial begin
      ADA_DCO = 1'b0;
      forever #10 ADA_DCO = ~ADA_DCO;         // 50 MHz
   end

   // ==============================
   // compare tasks
   // ==============================
   task automatic check_gate(input string name, input gate_t got, input gate_t exp);
      if (got !== exp) begin
         err_gate++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input axi_data_t got, input axi_data_t exp);
      if (got !== exp) begin
         err_reg++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_phase(input string name, input phase_e got, input phase_e exp);
      if (got !== exp) begin
         err_phase++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_fault(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         err_fault++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // ==============================
   // AXI4-Lite master
   // ==============================
   task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
      int stall;
      @(posedge ADA_DCO);
      i_awaddr  <= addr;
      i_awvalid <= 1'b1;
      i_wdata   <= data;
      i_wvalid  <= 1'b1;
      do @(negedge ADA_DCO); while (!(o_awready && o_wready));
      @(posedge ADA_DCO);                     // both channels taken here
      i_awvalid <= 1'b0;
      i_wvalid  <= 1'b0;
      stall = $urandom_range(2, 0);           // hold the response a while
      repeat (stall) @(posedge ADA_DCO);
      @(posedge ADA_DCO);
      i_bready <= 1'b1;
      do @(negedge ADA_DCO); while (!o_bvalid);
      check_reg("o_bresp", {30'd0, o_bresp}, 32'd0);
      @(posedge ADA_DCO);
      i_bready <= 1'b0;
   endtask

   task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
      int stall;
      @(posedge ADA_DCO);
      i_araddr  <= addr;
      i_arvalid <= 1'b1;
      do @(negedge ADA_DCO); while (!o_arready);
      @(posedge ADA_DCO);
      i_arvalid <= 1'b0;
      stall = $urandom_range(2, 0);
      repeat (stall) @(posedge ADA_DCO);
      @(posedge ADA_DCO);
      i_rready <= 1'b1;
      do @(negedge ADA_DCO); while (!o_rvalid);
      data = o_rdata;
      check_reg("o_rresp", {30'd0, o_rresp}, 32'd0);
      @(posedge ADA_DCO);
      i_rready <= 1'b0;
   endtask

   // ==============================
   // pattern interpreter
   // ==============================
   task automatic wait_then_check_gate(input int cycles, input gate_t exp);
      repeat (cycles) @(posedge ADA_DCO);
      @(negedge ADA_DCO);                     // gates settled mid-cycle
      check_gate("o_gate", o_gate, exp);
   endtask

   task automatic run_command(input int base);
      logic [3:0] cmd;
      axi_data_t  arg;
      axi_data_t  data;
      axi_data_t  expv;
      axi_data_t  rd;
      cmd  = pat[base][3:0];
      arg  = pat[base+1];
      data = pat[base+2];
      expv = pat[base+3];
      case (cmd)
         4'h1: axi_write(arg[4:0], data);
         4'h2: begin
            axi_read(arg[4:0], rd);
            check_reg($sformatf("o_rdata@%h", arg[4:0]), rd, expv);
            if (arg[4:0] == REG_STATUS) begin
               @(negedge ADA_DCO);            // fault pin vs STATUS bit 0
               check_fault("o_fault", o_fault, expv[0]);
            end
         end
         4'h3: begin                          // new tank sample pair
            @(posedge ADA_DCO);
            i_ada_data <= arg[13:0];
            i_adb_data <= data[13:0];
            wait_then_check_gate(40, expv[3:0]);
         end
         4'h4: begin                          // bit 0 ada, bit 1 adb
            @(posedge ADA_DCO);
            i_ada_or <= arg[0];
            i_adb_or <= arg[1];
            wait_then_check_gate(40, expv[3:0]);
         end
         4'h5: wait_then_check_gate(int'(arg), expv[3:0]);
         4'h6: begin
            axi_read(REG_STATUS, rd);
            check_phase("status phase", phase_e'(rd[2:1]), phase_e'(expv[1:0]));
         end
         default: begin
            err_other++;
            $display("unknown command %h on pattern line %0d", cmd, base / 4 + 1);
         end
      endcase
   endtask

   // ==============================
   // main sequence
   // ==============================
   initial begin
      i_rst      <= 1'b1;
      i_ada_data <= '0;
      i_adb_data <= '0;
      i_ada_or   <= 1'b0;
      i_adb_or   <= 1'b0;
      i_awaddr   <= '0;
      i_awvalid  <= 1'b0;
      i_wdata    <= '0;
      i_wvalid   <= 1'b0;
      i_bready   <= 1'b0;
      i_araddr   <= '0;
      i_arvalid  <= 1'b0;
      i_rready   <= 1'b0;
      void'($urandom(32'hb453_5721));         // stalls repeat run to run
      $readmemh("verification/bridge_patterns.txt", pat);
      n_cmds = 0;
      while (n_cmds < 64 && pat[4 * n_cmds][3:0] != 4'hf)
         n_cmds++;                            // stop at the end marker
      repeat (8) @(posedge ADA_DCO);
      i_rst <= 1'b0;
      for (int k = 0; k < n_cmds; k++)
         run_command(4 * k);
      @(negedge ADA_DCO);
      $display("errors: gate %0d, reg %0d, phase %0d, fault %0d, other %0d",
               err_gate, err_reg, err_phase, err_fault, err_other);
      if (err_gate + err_reg + err_phase + err_fault + err_other == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   // watchdog, 60 cycles per command plus reset margin
   initial begin
      int limit;
      @(posedge ADA_DCO);
      limit = n_cmds * 60 + 500;
      repeat (limit) @(posedge ADA_DCO);
      $display("timeout, patterns did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
   end

endmodule

//--- verification/bridge_patterns.txt
// columns: cmd arg data expect, all hex, one command per line
// 1 write addr data, 2 read addr expect, 3 sample ada adb gate, 4 over-range flags gate
// 5 wait cycles gate, 6 status phase, f end
2 00 0 0      // CTRL after reset
2 04 0 8      // theta pi/2
2 0c 0 5      // dead time
2 10 0 0      // no fault, idle
1 08 1a5 0
2 08 0 1a5
1 14 ff 0     // unmapped, dropped
2 14 0 0
3 0 1000 0    // disabled, gates off
1 00 3 0      // enable, theta mode
5 7 0 c       // bootstrap window
5 28 0 9      // running, adb > 0 at pi/2
6 0 0 3
3 0 3000 6
1 04 0 0      // theta 0
3 1000 0 6
3 3000 0 9
1 04 4 0      // theta pi/4
3 800 3800 6
3 3800 800 9
1 04 c 0      // theta 3pi/4
3 3800 3800 6
1 04 8 0
1 08 200 0    // band 512
1 00 5 0      // mixed mode
2 00 0 5
3 0 100 c     // inside band
3 0 800 9
3 0 3800 6
1 0c 14 0     // dead time 20
2 0c 0 14
3 0 800 9
3 0 3800 6
4 1 0 0       // ada over-range
2 10 0 7      // fault, run
4 0 0 0       // still latched
1 10 1 0      // fault clear
5 28 0 6
2 10 0 6
1 00 1 0      // mode off
5 28 0 0
f 0 0 0

//--- sim.f
design/hbridge_pkg.sv
design/axil_ctrl_regs.sv
design/adc_capture.sv
design/surface_law.sv
design/startup_seq.sv
design/dead_time_gen.sv
design/bridge_guard.sv
design/hybrid_bridge_top.sv
verification/hybrid_bridge_checker.sv
verification/tb_hybrid_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the H-bridge testbench, from the project root
# the run counts as passed only when the log holds the pass line

rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_hybrid_bridge -f sim.f \
   > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_hybrid_bridge > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log \
   && echo "run passed" \
   || { echo "run failed, see sim.log"; exit 1; }
